// ==== include/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define XLEN 32

// general register file
`define NUM_REGS 32
`define REG_ADDR_W 5

// first fetch address after reset
`define RESET_PC 32'h1c00_0000

`endif

// ==== design/isa_pkg.sv ====
package isa_pkg;

    // decoded instruction class
    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_add   = 4'd1,
        op_sub   = 4'd2,
        op_and   = 4'd3,
        op_or    = 4'd4,
        op_xor   = 4'd5,
        op_slt   = 4'd6,
        op_sltu  = 4'd7,
        op_addi  = 4'd8,
        op_lu12i = 4'd9,
        op_beq   = 4'd10,
        op_bne   = 4'd11,
        op_b     = 4'd12
    } opcode_e;

    // alu function, pass_b carries the lu12i.w immediate through
    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_slt    = 3'd5,
        alu_sltu   = 3'd6,
        alu_pass_b = 3'd7
    } alu_op_e;

endpackage

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

    // operand source seen by decode
    typedef enum logic [1:0] {
        fwd_file = 2'd0,
        fwd_ex   = 2'd1,
        fwd_wb   = 2'd2
    } fwd_src_e;

endpackage

// ==== design/fetch_unit.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module fetch_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    input  logic [`XLEN-1:0] inst_rdata,
    input  logic             flush,
    input  logic [`XLEN-1:0] redirect_pc,
    output logic             inst_re,
    output logic [`XLEN-1:0] inst_addr,
    output logic             if_valid,
    output logic [`XLEN-1:0] if_pc,
    output logic [`XLEN-1:0] if_inst
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] redir_pc;
    logic             drop;
    logic             accept;

    // address stays on pc until the word comes back
    assign inst_addr = pc;
    assign accept    = inst_re && inst_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_re <= 1'b0;
            pc      <= `RESET_PC;
            drop    <= 1'b0;
        end else begin
            inst_re <= 1'b1;
            if (flush) begin
                if (accept) begin
                    pc   <= redirect_pc;
                    drop <= 1'b0;
                end else begin
                    drop <= 1'b1;
                end
            end else if (accept) begin
                pc   <= drop ? redir_pc : pc + `XLEN'(4);
                drop <= 1'b0;
            end
        end
    end

    // target kept while the stale request finishes
    always_ff @(posedge clk) begin
        if (flush && !accept) begin
            redir_pc <= redirect_pc;
        end
    end

    // ******************************
    // IF/ID register
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= accept && !flush && !drop;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if_pc   <= pc;
            if_inst <= inst_rdata;
        end
    end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    if_valid,
    input  logic [`XLEN-1:0]        if_inst,
    input  logic [`XLEN-1:0]        if_pc,
    input  logic [`XLEN-1:0]        rj_data,
    input  logic [`XLEN-1:0]        rk_data,
    input  logic [`XLEN-1:0]        ex_result,
    input  logic [`XLEN-1:0]        wb_data,
    input  pipe_pkg::fwd_src_e      fwd_sel_j,
    input  pipe_pkg::fwd_src_e      fwd_sel_k,
    output logic [`REG_ADDR_W-1:0]  rj_addr,
    output logic [`REG_ADDR_W-1:0]  rk_addr,
    output logic                    id_ex_valid,
    output isa_pkg::opcode_e        id_ex_op,
    output isa_pkg::alu_op_e        id_ex_alu_op,
    output logic [`XLEN-1:0]        id_ex_pc,
    output logic [`XLEN-1:0]        id_ex_a,
    output logic [`XLEN-1:0]        id_ex_b,
    output logic [`XLEN-1:0]        id_ex_imm,
    output logic [`REG_ADDR_W-1:0]  id_ex_rd,
    output logic                    id_ex_rd_wen
);

    logic [`REG_ADDR_W-1:0] rd_f;
    logic [`REG_ADDR_W-1:0] rk_f;
    isa_pkg::opcode_e       dec_op;
    isa_pkg::alu_op_e       dec_alu_op;
    logic [`XLEN-1:0]       dec_imm;
    logic                   dec_writes;
    logic                   dec_use_imm;
    logic                   dec_src_rd;
    logic [`XLEN-1:0]       rj_fwd;
    logic [`XLEN-1:0]       rk_fwd;

    function automatic logic [`XLEN-1:0] fwd_pick(
        input pipe_pkg::fwd_src_e sel,
        input logic [`XLEN-1:0]   file_val,
        input logic [`XLEN-1:0]   ex_val,
        input logic [`XLEN-1:0]   wb_val
    );
        case (sel)
            pipe_pkg::fwd_ex: return ex_val;
            pipe_pkg::fwd_wb: return wb_val;
            default:          return file_val;
        endcase
    endfunction

    assign rd_f    = if_inst[4:0];
    assign rk_f    = if_inst[14:10];
    assign rj_addr = if_inst[9:5];
    // beq and bne compare rj against rd
    assign rk_addr = dec_src_rd ? rd_f : rk_f;

    always_comb begin
        dec_op      = isa_pkg::op_nop;
        dec_alu_op  = isa_pkg::alu_add;
        dec_imm     = '0;
        dec_writes  = 1'b0;
        dec_use_imm = 1'b0;
        dec_src_rd  = 1'b0;
        casez (if_inst[31:15])
            // 3R format
            17'h00020: begin
                dec_op     = isa_pkg::op_add;
                dec_writes = 1'b1;
            end
            17'h00022: begin
                dec_op     = isa_pkg::op_sub;
                dec_alu_op = isa_pkg::alu_sub;
                dec_writes = 1'b1;
            end
            17'h00024: begin
                dec_op     = isa_pkg::op_slt;
                dec_alu_op = isa_pkg::alu_slt;
                dec_writes = 1'b1;
            end
            17'h00025: begin
                dec_op     = isa_pkg::op_sltu;
                dec_alu_op = isa_pkg::alu_sltu;
                dec_writes = 1'b1;
            end
            17'h00029: begin
                dec_op     = isa_pkg::op_and;
                dec_alu_op = isa_pkg::alu_and;
                dec_writes = 1'b1;
            end
            17'h0002a: begin
                dec_op     = isa_pkg::op_or;
                dec_alu_op = isa_pkg::alu_or;
                dec_writes = 1'b1;
            end
            17'h0002b: begin
                dec_op     = isa_pkg::op_xor;
                dec_alu_op = isa_pkg::alu_xor;
                dec_writes = 1'b1;
            end
            // immediates
            17'b0000001010???????: begin
                dec_op      = isa_pkg::op_addi;
                dec_imm     = {{(`XLEN-12){if_inst[21]}}, if_inst[21:10]};
                dec_writes  = 1'b1;
                dec_use_imm = 1'b1;
            end
            17'b0001010??????????: begin
                dec_op      = isa_pkg::op_lu12i;
                dec_alu_op  = isa_pkg::alu_pass_b;
                dec_imm     = {if_inst[24:5], 12'b0};
                dec_writes  = 1'b1;
                dec_use_imm = 1'b1;
            end
            // branch offsets in words
            17'b010110???????????: begin
                dec_op     = isa_pkg::op_beq;
                dec_imm    = {{(`XLEN-16){if_inst[25]}}, if_inst[25:10]};
                dec_src_rd = 1'b1;
            end
            17'b010111???????????: begin
                dec_op     = isa_pkg::op_bne;
                dec_imm    = {{(`XLEN-16){if_inst[25]}}, if_inst[25:10]};
                dec_src_rd = 1'b1;
            end
            17'b010100???????????: begin
                dec_op  = isa_pkg::op_b;
                dec_imm = {{(`XLEN-26){if_inst[9]}}, if_inst[9:0], if_inst[25:10]};
            end
            default: begin
                dec_op = isa_pkg::op_nop;
            end
        endcase
    end

    assign rj_fwd = fwd_pick(fwd_sel_j, rj_data, ex_result, wb_data);
    assign rk_fwd = fwd_pick(fwd_sel_k, rk_data, ex_result, wb_data);

    // ******************************
    // ID/EX register
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex_valid <= 1'b0;
        end else begin
            id_ex_valid <= if_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_op     <= dec_op;
        id_ex_alu_op <= dec_alu_op;
        id_ex_pc     <= if_pc;
        id_ex_a      <= rj_fwd;
        id_ex_b      <= dec_use_imm ? dec_imm : rk_fwd;
        id_ex_imm    <= dec_imm;
        id_ex_rd     <= rd_f;
        id_ex_rd_wen <= dec_writes && (rd_f != '0);
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rj_addr,
    input  logic [`REG_ADDR_W-1:0] rk_addr,
    input  logic                   wb_we,
    input  logic [`REG_ADDR_W-1:0] wb_addr,
    input  logic [`XLEN-1:0]       wb_data,
    output logic [`XLEN-1:0]       rj_data,
    output logic [`XLEN-1:0]       rk_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // r0 is hardwired
    assign rj_data = (rj_addr == '0) ? '0 : regs[rj_addr];
    assign rk_data = (rk_addr == '0) ? '0 : regs[rk_addr];

endmodule

// ==== design/execute_unit.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module execute_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   id_ex_valid,
    input  isa_pkg::opcode_e       id_ex_op,
    input  isa_pkg::alu_op_e       id_ex_alu_op,
    input  logic [`XLEN-1:0]       id_ex_pc,
    input  logic [`XLEN-1:0]       id_ex_a,
    input  logic [`XLEN-1:0]       id_ex_b,
    input  logic [`XLEN-1:0]       id_ex_imm,
    input  logic [`REG_ADDR_W-1:0] id_ex_rd,
    input  logic                   id_ex_rd_wen,
    output logic [`XLEN-1:0]       ex_result,
    output logic [`REG_ADDR_W-1:0] ex_rd,
    output logic                   ex_rd_wen,
    output logic                   branch_taken,
    output logic [`XLEN-1:0]       branch_target,
    output logic                   wb_we,
    output logic [`REG_ADDR_W-1:0] wb_addr,
    output logic [`XLEN-1:0]       wb_data,
    output logic [`XLEN-1:0]       wb_pc
);

    logic operands_eq;

    // ******************************
    // ALU
    // ******************************
    always_comb begin
        case (id_ex_alu_op)
            isa_pkg::alu_add:    ex_result = id_ex_a + id_ex_b;
            isa_pkg::alu_sub:    ex_result = id_ex_a - id_ex_b;
            isa_pkg::alu_and:    ex_result = id_ex_a & id_ex_b;
            isa_pkg::alu_or:     ex_result = id_ex_a | id_ex_b;
            isa_pkg::alu_xor:    ex_result = id_ex_a ^ id_ex_b;
            isa_pkg::alu_slt:    ex_result = {{(`XLEN-1){1'b0}}, $signed(id_ex_a) < $signed(id_ex_b)};
            isa_pkg::alu_sltu:   ex_result = {{(`XLEN-1){1'b0}}, id_ex_a < id_ex_b};
            isa_pkg::alu_pass_b: ex_result = id_ex_b;
            default:             ex_result = id_ex_a + id_ex_b;
        endcase
    end

    assign ex_rd     = id_ex_rd;
    assign ex_rd_wen = id_ex_valid && id_ex_rd_wen;

    // branch resolve, b is unconditional
    assign operands_eq   = (id_ex_a == id_ex_b);
    assign branch_taken  = id_ex_valid &&
                           ((id_ex_op == isa_pkg::op_beq && operands_eq) ||
                            (id_ex_op == isa_pkg::op_bne && !operands_eq) ||
                            (id_ex_op == isa_pkg::op_b));
    assign branch_target = id_ex_pc + {id_ex_imm[`XLEN-3:0], 2'b00};

    // ******************************
    // EX/WB register
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= ex_rd_wen;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= id_ex_rd;
        wb_data <= ex_result;
        wb_pc   <= id_ex_pc;
    end

endmodule

// ==== design/hazard_ctrl.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module hazard_ctrl (
    input  logic [`REG_ADDR_W-1:0] rj_addr,
    input  logic [`REG_ADDR_W-1:0] rk_addr,
    input  logic [`REG_ADDR_W-1:0] ex_rd,
    input  logic                   ex_rd_wen,
    input  logic [`REG_ADDR_W-1:0] wb_addr,
    input  logic                   wb_we,
    input  logic                   branch_taken,
    input  logic [`XLEN-1:0]       branch_target,
    output pipe_pkg::fwd_src_e     fwd_sel_j,
    output pipe_pkg::fwd_src_e     fwd_sel_k,
    output logic                   flush,
    output logic [`XLEN-1:0]       redirect_pc
);

    // youngest producer wins
    function automatic pipe_pkg::fwd_src_e pick_src(
        input logic [`REG_ADDR_W-1:0] src,
        input logic [`REG_ADDR_W-1:0] ex_dst,
        input logic                   ex_wen,
        input logic [`REG_ADDR_W-1:0] wb_dst,
        input logic                   wb_wen
    );
        if (src == '0) begin
            return pipe_pkg::fwd_file;
        end
        if (ex_wen && ex_dst == src) begin
            return pipe_pkg::fwd_ex;
        end
        if (wb_wen && wb_dst == src) begin
            return pipe_pkg::fwd_wb;
        end
        return pipe_pkg::fwd_file;
    endfunction

    assign fwd_sel_j = pick_src(rj_addr, ex_rd, ex_rd_wen, wb_addr, wb_we);
    assign fwd_sel_k = pick_src(rk_addr, ex_rd, ex_rd_wen, wb_addr, wb_we);

    // taken branch kills IF/ID and the fetch in flight
    assign flush       = branch_taken;
    assign redirect_pc = branch_target;

endmodule

// ==== design/core_top.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module core_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`XLEN-1:0]       inst_rdata,
    input  logic                   inst_valid,
    output logic                   inst_re,
    output logic [`XLEN-1:0]       inst_addr,
    output logic [`XLEN-1:0]       debug_wb_pc,
    output logic [3:0]             debug_wb_rf_we,
    output logic [`REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [`XLEN-1:0]       debug_wb_rf_wdata
);

    logic                   if_valid;
    logic [`XLEN-1:0]       if_pc;
    logic [`XLEN-1:0]       if_inst;

    logic [`REG_ADDR_W-1:0] rj_addr;
    logic [`REG_ADDR_W-1:0] rk_addr;
    logic [`XLEN-1:0]       rj_data;
    logic [`XLEN-1:0]       rk_data;

    logic                   id_ex_valid;
    isa_pkg::opcode_e       id_ex_op;
    isa_pkg::alu_op_e       id_ex_alu_op;
    logic [`XLEN-1:0]       id_ex_pc;
    logic [`XLEN-1:0]       id_ex_a;
    logic [`XLEN-1:0]       id_ex_b;
    logic [`XLEN-1:0]       id_ex_imm;
    logic [`REG_ADDR_W-1:0] id_ex_rd;
    logic                   id_ex_rd_wen;

    logic [`XLEN-1:0]       ex_result;
    logic [`REG_ADDR_W-1:0] ex_rd;
    logic                   ex_rd_wen;
    logic                   branch_taken;
    logic [`XLEN-1:0]       branch_target;

    logic                   wb_we;
    logic [`REG_ADDR_W-1:0] wb_addr;
    logic [`XLEN-1:0]       wb_data;
    logic [`XLEN-1:0]       wb_pc;

    pipe_pkg::fwd_src_e     fwd_sel_j;
    pipe_pkg::fwd_src_e     fwd_sel_k;
    logic                   flush;
    logic [`XLEN-1:0]       redirect_pc;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .inst_rdata  (inst_rdata),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .inst_re     (inst_re),
        .inst_addr   (inst_addr),
        .if_valid    (if_valid),
        .if_pc       (if_pc),
        .if_inst     (if_inst)
    );

    decode_stage u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .if_valid     (if_valid),
        .if_inst      (if_inst),
        .if_pc        (if_pc),
        .rj_data      (rj_data),
        .rk_data      (rk_data),
        .ex_result    (ex_result),
        .wb_data      (wb_data),
        .fwd_sel_j    (fwd_sel_j),
        .fwd_sel_k    (fwd_sel_k),
        .rj_addr      (rj_addr),
        .rk_addr      (rk_addr),
        .id_ex_valid  (id_ex_valid),
        .id_ex_op     (id_ex_op),
        .id_ex_alu_op (id_ex_alu_op),
        .id_ex_pc     (id_ex_pc),
        .id_ex_a      (id_ex_a),
        .id_ex_b      (id_ex_b),
        .id_ex_imm    (id_ex_imm),
        .id_ex_rd     (id_ex_rd),
        .id_ex_rd_wen (id_ex_rd_wen)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rj_addr (rj_addr),
        .rk_addr (rk_addr),
        .wb_we   (wb_we),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .rj_data (rj_data),
        .rk_data (rk_data)
    );

    execute_unit u_exec (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_ex_valid   (id_ex_valid),
        .id_ex_op      (id_ex_op),
        .id_ex_alu_op  (id_ex_alu_op),
        .id_ex_pc      (id_ex_pc),
        .id_ex_a       (id_ex_a),
        .id_ex_b       (id_ex_b),
        .id_ex_imm     (id_ex_imm),
        .id_ex_rd      (id_ex_rd),
        .id_ex_rd_wen  (id_ex_rd_wen),
        .ex_result     (ex_result),
        .ex_rd         (ex_rd),
        .ex_rd_wen     (ex_rd_wen),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .wb_we         (wb_we),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .wb_pc         (wb_pc)
    );

    hazard_ctrl u_hazard (
        .rj_addr       (rj_addr),
        .rk_addr       (rk_addr),
        .ex_rd         (ex_rd),
        .ex_rd_wen     (ex_rd_wen),
        .wb_addr       (wb_addr),
        .wb_we         (wb_we),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .fwd_sel_j     (fwd_sel_j),
        .fwd_sel_k     (fwd_sel_k),
        .flush         (flush),
        .redirect_pc   (redirect_pc)
    );

    // trace shows the EX/WB register, byte enables all follow wb_we
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = {4{wb_we}};
    assign debug_wb_rf_wnum  = wb_addr;
    assign debug_wb_rf_wdata = wb_data;

endmodule

// ==== tests/tb_core.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module tb_core;

    localparam int GOLDEN_WORDS = 256;
    localparam int FIRST_REQ_LIMIT = 50;
    localparam int TRACE_LIMIT = 2000;
    localparam int SETTLE_CYCLES = 16;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic [`XLEN-1:0]       inst_rdata;
    logic                   inst_valid;
    logic                   inst_re;
    logic [`XLEN-1:0]       inst_addr;
    logic [`XLEN-1:0]       debug_wb_pc;
    logic [3:0]             debug_wb_rf_we;
    logic [`REG_ADDR_W-1:0] debug_wb_rf_wnum;
    logic [`XLEN-1:0]       debug_wb_rf_wdata;

    // count, program, count, trace triples
    logic [`XLEN-1:0] golden [GOLDEN_WORDS];
    int               prog_len;
    int               trace_len;
    int               trace_base;
    int               seen;
    int               entry;

    logic [15:0]      lfsr;
    logic             req_busy;
    logic [`XLEN-1:0] req_addr;
    int               wait_left;
    int               cycles;

    core_top u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_rdata        (inst_rdata),
        .inst_valid        (inst_valid),
        .inst_re           (inst_re),
        .inst_addr         (inst_addr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #20 clk = ~clk;

    // ******************************
    // error reporting
    // ******************************
    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string sig, input logic [`XLEN-1:0] expected,
                                 input logic [`XLEN-1:0] actual);
        $display("FAILED time=%0t signal=%s expected=%h actual=%h", $time, sig, expected, actual);
        stop_run();
    endtask

    task automatic explain_failure(input string why);
        $display("Error at time %0t: %s", $time, why);
        stop_run();
    endtask

    // galois step with taps at 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    // two bits give 0 to 3 wait cycles
    task automatic draw_wait(output int wait_cycles);
        wait_cycles = 0;
        for (int i = 0; i < 2; i++) begin
            wait_cycles = (wait_cycles << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic read_program(input logic [`XLEN-1:0] addr, output logic [`XLEN-1:0] word);
        logic [`XLEN-1:0] offset;
        offset = addr - `RESET_PC;
        assert (addr[1:0] == 2'b00 && (offset >> 2) < prog_len)
        else explain_failure($sformatf("fetch from %h is outside the program", addr));
        word = golden[1 + (offset >> 2)];
    endtask

    // ******************************
    // instruction memory model
    // ******************************
    always @(posedge clk) begin
        #2;
        if (inst_valid) begin
            // word was taken on the edge just passed
            inst_valid = 1'b0;
            req_busy   = 1'b0;
        end
        if (req_busy) begin
            assert (inst_addr == req_addr)
            else show_mismatch("inst_addr", req_addr, inst_addr);
        end
        if (inst_re && !req_busy) begin
            req_busy = 1'b1;
            req_addr = inst_addr;
            draw_wait(wait_left);
        end else if (req_busy && wait_left > 0) begin
            wait_left--;
        end
        if (req_busy && wait_left == 0) begin
            read_program(req_addr, inst_rdata);
            inst_valid = 1'b1;
        end
    end

    // trace outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (inst_re == 1'b0)
            else show_mismatch("inst_re", '0, inst_re);
            assert (debug_wb_rf_we == 4'h0)
            else show_mismatch("debug_wb_rf_we", '0, debug_wb_rf_we);
        end else if (debug_wb_rf_we != 4'h0) begin
            assert (debug_wb_rf_we == 4'hf)
            else show_mismatch("debug_wb_rf_we", 4'hf, debug_wb_rf_we);
            assert (debug_wb_rf_wnum != '0)
            else explain_failure("a write to r0 appeared on the trace");
            assert (seen < trace_len)
            else explain_failure("trace entry beyond the expected count");
            entry = trace_base + 3 * seen;
            assert (debug_wb_pc == golden[entry])
            else show_mismatch("debug_wb_pc", golden[entry], debug_wb_pc);
            assert (debug_wb_rf_wnum == golden[entry + 1][`REG_ADDR_W-1:0])
            else show_mismatch("debug_wb_rf_wnum", golden[entry + 1], debug_wb_rf_wnum);
            assert (debug_wb_rf_wdata == golden[entry + 2])
            else show_mismatch("debug_wb_rf_wdata", golden[entry + 2], debug_wb_rf_wdata);
            seen++;
        end
    end

    // ******************************
    // main sequence
    // ******************************
    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst_rdata = '0;
        lfsr       = 16'd46;
        req_busy   = 1'b0;
        req_addr   = '0;
        wait_left  = 0;
        seen       = 0;
        entry      = 0;

        $readmemh("tests/golden_trace.txt", golden);
        prog_len   = int'(golden[0]);
        trace_len  = int'(golden[prog_len + 1]);
        trace_base = prog_len + 2;
        if (prog_len <= 0 || trace_len <= 0 || trace_base + 3 * trace_len > GOLDEN_WORDS) begin
            explain_failure("golden file counts are missing or out of range");
        end

        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        cycles = 0;
        while (inst_re !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > FIRST_REQ_LIMIT) begin
                explain_failure("no instruction request after reset");
            end
        end
        assert (inst_addr == `RESET_PC)
        else show_mismatch("inst_addr", `RESET_PC, inst_addr);

        cycles = 0;
        while (seen < trace_len) begin
            @(posedge clk);
            cycles++;
            if (cycles > TRACE_LIMIT) begin
                explain_failure("trace did not complete within the cycle limit");
            end
        end

        // program ends in a branch to itself so nothing more may retire
        repeat (SETTLE_CYCLES) @(posedge clk);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tests/golden_trace.txt ====
// program: word count, then instruction words from the reset pc, four per line
// trace: entry count, then one write per line as pc, register number, value
00000022
142468a1 0299e021 02bffc02 00100823  // 1c000000 lu12i.w, addi.w, addi.w r2 -1, add.w
00110464 00120085 00128086 00148827  // 1c000010 sub.w, slt, sltu, and
001504a8 00158909 02801420 0010040a  // 1c000020 or, xor, addi.w to r0, add.w from r0
580008a6 0280440b 5c000ca6 0281540c  // 1c000030 beq not taken, addi.w, bne taken, skipped
0281980d 58000c2a 0281dc0c 0282200d  // 1c000040 skipped, beq taken, skipped, skipped
0280056c 50000800 0282640d 5c00118c  // 1c000050 addi.w, b, skipped, bne not taken
00102d8d 0280080f 02bffdef 5ffffde0  // 1c000060 add.w, addi.w, loop body, bne back
15fffff0 00123e11 0012c1f2 50000000  // 1c000070 lu12i.w, slt, sltu, b to self
00000000 00000000                    // 1c000080 padding, decodes as nop
00000014
1c000000 00000001 12345000
1c000004 00000001 12345678
1c000008 00000002 ffffffff
1c00000c 00000003 12345677
1c000010 00000004 ffffffff
1c000014 00000005 00000001
1c000018 00000006 00000000
1c00001c 00000007 12345678
1c000020 00000008 12345679
1c000024 00000009 edcba986
1c00002c 0000000a 12345678
1c000034 0000000b 00000011
1c000050 0000000c 00000012
1c000060 0000000d 00000023
1c000064 0000000f 00000002
1c000068 0000000f 00000001
1c000068 0000000f 00000000
1c000070 00000010 fffff000
1c000074 00000011 00000001
1c000078 00000012 00000001

// ==== sim.f ====
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_unit.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_unit.sv
design/hazard_ctrl.sv
design/core_top.sv
tests/tb_core.sv

// ==== Bender.yml ====
package:
  name: la32_pipe_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/isa_pkg.sv
      - design/pipe_pkg.sv
      - design/fetch_unit.sv
      - design/decode_stage.sv
      - design/reg_file.sv
      - design/execute_unit.sv
      - design/hazard_ctrl.sv
      - design/core_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/tb_core.sv
